// File: bench/nmi_checker.sv
// bus and pin checker: shadow registers, reference read model, uart frame decoder and error count
`timescale 1ns/1ps
`default_nettype none

module nmi_checker #(
  parameter int NUM_GPIO = 8,
  parameter int UART_DIV = 8
) (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire nmi_pkg::nmi_rsp_t   nmi_rsp_i,
  input  wire logic                uart_tx_i,
  input  wire logic [2:0]          irq_i,
  input  wire logic [NUM_GPIO-1:0] gpio_in_i,
  input  wire logic [NUM_GPIO-1:0] gpio_out_i,
  input  wire logic [NUM_GPIO-1:0] gpio_oe_i,
  input  wire logic                chk_stb_i,
  input  wire logic                chk_rst_i,
  input  wire logic [2:0]          test_id_i,
  input  wire logic [31:0]         addr_i,
  input  wire logic [31:0]         wdata_i,
  input  wire logic [3:0]          wstrb_i,
  input  wire logic [31:0]         rdata_i,
  input  wire logic                use_exp_i,
  input  wire logic [31:0]         exp_i,
  output int                       err_cnt_o,
  output int                       frame_cnt_o
);

  logic [NUM_GPIO-1:0] dir_s;
  logic [NUM_GPIO-1:0] out_s;
  logic [15:0]         div_s;
  logic [1:0]          tctl_s [2];
  logic [31:0]         reload_s [2];
  logic [7:0]          byte_q [$];
  logic [9:0]          frame_v;
  logic                mon_act;
  int                  mon_cyc;
  int                  mon_bit;
  int                  done_cnt;
  int                  data_wr_cnt;
  int                  errs = 0;
  int                  frames = 0;

  function automatic string test_name(logic [2:0] id);
    case (id)
      3'd0:    return "reset";
      3'd1:    return "gpio";
      3'd2:    return "timer";
      3'd3:    return "uart";
      default: return "unmapped";
    endcase
  endfunction

  function automatic logic [31:0] strobe_merge(logic [31:0] old_v, logic [31:0] new_v,
                                               logic [3:0] strb);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  // expected read data from the register map and the shadow copies
  function automatic logic [31:0] ref_read(logic [31:0] addr);
    int t;
    t = int'(addr[12]);
    if (addr[31:24] != 8'h10) begin
      return 32'h0;
    end
    case (addr[15:8])
      8'h00: begin
        case (addr[5:2])
          4'd0:    return 32'(dir_s);
          4'd1:    return 32'(out_s);
          4'd2:    return 32'(gpio_in_i);
          default: return 32'h0;
        endcase
      end
      8'h10: begin
        if (addr[5:2] == 4'd0) begin
          return 32'(div_s);
        end
      end
      8'h20, 8'h30: begin
        if (addr[5:2] == 4'd0) begin
          return 32'(tctl_s[t]);
        end else if (addr[5:2] == 4'd1) begin
          return reload_s[t];
        end
      end
      default: return 32'h0;
    endcase
    return 32'h0;
  endfunction

  task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s %s: expected %h, actual %h", test_name(test_id_i), what, exp, act);
    errs++;
  endtask

  always @(posedge clk_i) begin : check_proc
    logic [31:0] exp;
    logic [31:0] merged;
    logic [9:0]  want;
    int          t;
    if (reset_i) begin
      dir_s       = '0;
      out_s       = '0;
      div_s       = 16'd16;
      tctl_s[0]   = '0;
      tctl_s[1]   = '0;
      reload_s[0] = '0;
      reload_s[1] = '0;
      mon_act     = 1'b0;
      done_cnt    = 0;
      data_wr_cnt = 0;
      byte_q.delete();
    end else begin
      if (irq_i[0]) begin
        done_cnt++;
      end
      // frame decoder, samples the line at the middle of each bit
      if (!mon_act) begin
        if (!uart_tx_i) begin
          mon_act = 1'b1;
          mon_cyc = 1;
          mon_bit = 0;
        end
      end else begin
        mon_cyc++;
        if (mon_cyc == UART_DIV / 2 + mon_bit * UART_DIV) begin
          frame_v[mon_bit] = uart_tx_i;
          mon_bit++;
          if (mon_bit == 10) begin
            mon_act = 1'b0;
            frames++;
            if (byte_q.size() == 0) begin
              $display("uart sent a frame although no byte was written");
              errs++;
            end else begin
              want = {1'b1, byte_q.pop_front(), 1'b0};
              if (frame_v !== want) begin
                mismatch("uart frame", 32'(want), 32'(frame_v));
              end
            end
          end
        end
      end
      if (chk_stb_i && chk_rst_i) begin
        if (uart_tx_i !== 1'b1) mismatch("uart_tx_o", 32'h1, 32'(uart_tx_i));
        if (irq_i !== 3'b000) mismatch("irq_o", 32'h0, 32'(irq_i));
        if (gpio_out_i !== '0) mismatch("gpio_out_o", 32'h0, 32'(gpio_out_i));
        if (gpio_oe_i !== '0) mismatch("gpio_oe_o", 32'h0, 32'(gpio_oe_i));
        if (nmi_rsp_i.ready !== 1'b0) mismatch("ready", 32'h0, 32'(nmi_rsp_i.ready));
      end else if (chk_stb_i) begin
        t   = int'(addr_i[12]);
        exp = use_exp_i ? exp_i : ref_read(addr_i);
        if (wstrb_i == 4'h0) begin
          if (rdata_i !== exp) begin
            mismatch($sformatf("read %h", addr_i), exp, rdata_i);
          end
          // timer irq follows the flag masked by irq enable
          if (use_exp_i && addr_i[31:24] == 8'h10 && addr_i[15:13] == 3'b001 &&
              addr_i[11:8] == 4'h0 && addr_i[5:2] == 4'd2) begin
            if (irq_i[1+t] !== (exp_i[0] & tctl_s[t][1])) begin
              mismatch("timer irq", 32'(exp_i[0] & tctl_s[t][1]), 32'(irq_i[1+t]));
            end
          end
        end else if (addr_i[31:24] == 8'h10) begin
          case (addr_i[15:8])
            8'h00: begin
              merged = strobe_merge(32'(addr_i[5:2] == 4'd0 ? dir_s : out_s), wdata_i, wstrb_i);
              if (addr_i[5:2] == 4'd0) dir_s = merged[NUM_GPIO-1:0];
              if (addr_i[5:2] == 4'd1) out_s = merged[NUM_GPIO-1:0];
            end
            8'h10: begin
              if (addr_i[5:2] == 4'd0) div_s = wdata_i[15:0];
              if (addr_i[5:2] == 4'd1) begin
                if (done_cnt < data_wr_cnt) begin
                  $display("uart data write was acked before the previous frame ended");
                  errs++;
                end
                data_wr_cnt++;
                byte_q.push_back(wdata_i[7:0]);
              end
            end
            8'h20, 8'h30: begin
              if (addr_i[5:2] == 4'd0) tctl_s[t] = wdata_i[1:0];
              if (addr_i[5:2] == 4'd1) reload_s[t] = wdata_i;
            end
            default: ;
          endcase
        end
        if (chk_stb_i && gpio_out_i !== out_s) mismatch("gpio_out_o", 32'(out_s), 32'(gpio_out_i));
        if (chk_stb_i && gpio_oe_i !== dir_s) mismatch("gpio_oe_o", 32'(dir_s), 32'(gpio_oe_i));
      end
    end
  end

  assign err_cnt_o   = errs;
  assign frame_cnt_o = frames;

endmodule

`default_nettype wire

// File: bench/tb_top.sv
// testbench top: clock, reset, bus master tasks and the test sequence for the peripheral wrapper
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import nmi_pkg::*;

  localparam int          NUM_GPIO   = 8;
  localparam int          MAX_CYCLES = 4000;
  localparam logic [31:0] GPIO_BASE  = 32'h1000_0000;
  localparam logic [31:0] UART_BASE  = 32'h1000_1000;
  localparam logic [31:0] TIM0_BASE  = 32'h1000_2000;
  localparam logic [31:0] TIM1_BASE  = 32'h1000_3000;

  logic                clk_i;
  logic                reset_i;
  nmi_req_t            nmi_req;
  nmi_rsp_t            nmi_rsp;
  logic [NUM_GPIO-1:0] gpio_in;
  logic [NUM_GPIO-1:0] gpio_out;
  logic [NUM_GPIO-1:0] gpio_oe;
  logic                uart_tx;
  logic [2:0]          irq;
  logic                chk_stb;
  logic                chk_rst;
  logic [2:0]          test_id;
  logic [31:0]         c_addr;
  logic [31:0]         c_wdata;
  logic [3:0]          c_wstrb;
  logic [31:0]         c_rdata;
  logic                c_use_exp;
  logic [31:0]         c_exp;
  logic [31:0]         tbase;
  logic [31:0]         rnd;
  int                  chk_errs;
  int                  frames;
  int                  tb_errs = 0;
  int                  prev_errs = 0;
  int                  failed_tests = 0;
  int                  cycles = 0;
  int                  seed = 73451;

  nmi_periph_wrapper #(
    .NUM_GPIO(NUM_GPIO)
  ) u_nmi_periph_wrapper (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .nmi_req_i (nmi_req),
    .nmi_rsp_o (nmi_rsp),
    .gpio_in_i (gpio_in),
    .gpio_out_o(gpio_out),
    .gpio_oe_o (gpio_oe),
    .uart_tx_o (uart_tx),
    .irq_o     (irq)
  );

  nmi_checker #(
    .NUM_GPIO(NUM_GPIO),
    .UART_DIV(8)
  ) u_checker (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .nmi_rsp_i  (nmi_rsp),
    .uart_tx_i  (uart_tx),
    .irq_i      (irq),
    .gpio_in_i  (gpio_in),
    .gpio_out_i (gpio_out),
    .gpio_oe_i  (gpio_oe),
    .chk_stb_i  (chk_stb),
    .chk_rst_i  (chk_rst),
    .test_id_i  (test_id),
    .addr_i     (c_addr),
    .wdata_i    (c_wdata),
    .wstrb_i    (c_wstrb),
    .rdata_i    (c_rdata),
    .use_exp_i  (c_use_exp),
    .exp_i      (c_exp),
    .err_cnt_o  (chk_errs),
    .frame_cnt_o(frames)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // stop a run that hangs on the bus or on a missing event
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // one transfer followed by a one-cycle strobe that hands the result to the checker
  task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, input logic use_exp, input logic [31:0] exp);
    logic [31:0] rd;
    @(negedge clk_i);
    nmi_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    @(posedge clk_i);
    while (!nmi_rsp.ready) begin
      @(posedge clk_i);
    end
    rd = nmi_rsp.rdata;
    @(negedge clk_i);
    nmi_req.valid = 1'b0;
    c_addr        = addr;
    c_wdata       = wdata;
    c_wstrb       = wstrb;
    c_rdata       = rd;
    c_use_exp     = use_exp;
    c_exp         = exp;
    chk_stb       = 1'b1;
    @(negedge clk_i);
    chk_stb = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    bus_xfer(addr, wdata, wstrb, 1'b0, 32'h0);
  endtask

  task automatic bus_read(input logic [31:0] addr);
    bus_xfer(addr, 32'h0, 4'h0, 1'b0, 32'h0);
  endtask

  task automatic bus_read_exp(input logic [31:0] addr, input logic [31:0] exp);
    bus_xfer(addr, 32'h0, 4'h0, 1'b1, exp);
  endtask

  task automatic wait_irq(input int idx);
    int n;
    n = 0;
    while (!irq[idx] && n < 100) begin
      @(posedge clk_i);
      n++;
    end
    if (!irq[idx]) begin
      $display("irq bit %0d did not rise within 100 cycles", idx);
      tb_errs++;
    end
  endtask

  task automatic wait_frames(input int count);
    int n;
    n = 0;
    while (frames < count && n < 400) begin
      @(posedge clk_i);
      n++;
    end
    if (frames < count) begin
      $display("only %0d of %0d uart frames were seen", frames, count);
      tb_errs++;
    end
  endtask

  task automatic end_test(input string name);
    int now;
    now = chk_errs + tb_errs;
    if (now == prev_errs) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, now - prev_errs);
      failed_tests++;
    end
    prev_errs = now;
  endtask

  initial begin
    reset_i   = 1'b1;
    nmi_req   = '0;
    gpio_in   = '0;
    chk_stb   = 1'b0;
    chk_rst   = 1'b0;
    test_id   = 3'd0;
    c_addr    = '0;
    c_wdata   = '0;
    c_wstrb   = '0;
    c_rdata   = '0;
    c_use_exp = 1'b0;
    c_exp     = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    chk_rst = 1'b1;
    chk_stb = 1'b1;
    @(negedge clk_i);
    chk_stb = 1'b0;
    chk_rst = 1'b0;
    bus_read(UART_BASE);
    end_test("reset state");

    test_id = 3'd1;
    for (int i = 0; i < 4; i++) begin
      bus_write(GPIO_BASE, $random(seed), 4'hf);
      bus_write(GPIO_BASE + 4, $random(seed), 4'hf);
      bus_write(GPIO_BASE + 4, $random(seed), 4'b0001 << i);
      bus_write(GPIO_BASE, $random(seed), 4'b0010);
      bus_read(GPIO_BASE);
      bus_read(GPIO_BASE + 4);
    end
    rnd = $random(seed);
    @(negedge clk_i);
    gpio_in = rnd[NUM_GPIO-1:0];
    repeat (3) @(negedge clk_i);
    bus_read(GPIO_BASE + 8);
    end_test("gpio");

    test_id = 3'd2;
    for (int t = 0; t < 2; t++) begin
      tbase = (t == 0) ? TIM0_BASE : TIM1_BASE;
      bus_write(tbase + 4, 32'd20, 4'hf);
      bus_write(tbase, 32'd3, 4'hf);
      if (t == 0) begin
        bus_read_exp(TIM1_BASE + 12, 32'h0);
      end
      wait_irq(t + 1);
      bus_read_exp(tbase + 8, 32'h1);
      // stop the count, keep irq enable, then clear the flag
      bus_write(tbase, 32'd2, 4'hf);
      bus_write(tbase + 8, 32'h1, 4'hf);
      bus_read_exp(tbase + 8, 32'h0);
      bus_read(tbase);
      bus_read(tbase + 4);
    end
    end_test("timer");

    test_id = 3'd3;
    bus_write(UART_BASE, 32'd8, 4'hf);
    bus_read(UART_BASE);
    bus_write(UART_BASE + 4, $random(seed), 4'b0001);
    bus_write(UART_BASE + 4, $random(seed), 4'b0001);
    wait_frames(2);
    end_test("uart");

    test_id = 3'd4;
    bus_read(32'h1000_7000);
    bus_read(32'h2000_0004);
    bus_write(32'h1000_7004, $random(seed), 4'hf);
    bus_write(32'h2000_0000, $random(seed), 4'hf);
    bus_write(32'h2000_2004, $random(seed), 4'hf);
    bus_read(GPIO_BASE);
    bus_read(GPIO_BASE + 4);
    bus_read(TIM0_BASE + 4);
    bus_read(TIM1_BASE + 4);
    bus_read(UART_BASE);
    bus_read_exp(UART_BASE + 8, 32'h0);
    end_test("unmapped");

    repeat (4) @(negedge clk_i);
    $display("tests 5, passed %0d, failed %0d, errors %0d", 5 - failed_tests, failed_tests,
             chk_errs + tb_errs);
    if (chk_errs + tb_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rtl/nmi_pkg.sv
rtl/periph_pkg.sv
rtl/nmi_gpio.sv
rtl/nmi_timer.sv
rtl/nmi_uart_tx.sv
rtl/nmi_periph_wrapper.sv
bench/nmi_checker.sv
bench/tb_top.sv

// File: rtl/nmi_gpio.sv
// gpio block: direction and output registers with byte strobes, synchronized input pins
`timescale 1ns/1ps
`default_nettype none

module nmi_gpio #(
  parameter int NUM_GPIO = 8
) (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire nmi_pkg::nmi_req_t   req_i,
  output nmi_pkg::nmi_rsp_t        rsp_o,
  input  wire logic [NUM_GPIO-1:0] gpio_in_i,
  output logic [NUM_GPIO-1:0]      gpio_out_o,
  output logic [NUM_GPIO-1:0]      gpio_oe_o
);
  import nmi_pkg::*;
  import periph_pkg::*;

  reg_off_e            off;
  logic                acc;
  logic                wr;
  logic                ready_q;
  logic [NUM_GPIO-1:0] dir_q;
  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] in_meta_q;
  logic [NUM_GPIO-1:0] in_sync_q;
  logic [NMI_DW-1:0]   dir_wr;
  logic [NMI_DW-1:0]   out_wr;
  logic [NMI_DW-1:0]   rdata;
  logic [NMI_DW-1:0]   rdata_q;

  function automatic logic [NMI_DW-1:0] byte_merge(logic [NMI_DW-1:0] old_v,
                                                   logic [NMI_DW-1:0] new_v,
                                                   logic [NMI_SW-1:0] strb);
    logic [NMI_DW-1:0] res;
    res = old_v;
    for (int i = 0; i < NMI_SW; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_v[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign off    = reg_off_e'(req_i.addr[5:2]);
  assign wr     = |req_i.wstrb;
  assign acc    = req_i.valid && !ready_q;
  assign dir_wr = byte_merge(NMI_DW'(dir_q), req_i.wdata, req_i.wstrb);
  assign out_wr = byte_merge(NMI_DW'(out_q), req_i.wdata, req_i.wstrb);

  always_comb begin
    case (off)
      OFF_CTRL: rdata = NMI_DW'(dir_q);
      OFF_DATA: rdata = NMI_DW'(out_q);
      OFF_STAT: rdata = NMI_DW'(in_sync_q);
      default:  rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
      dir_q   <= '0;
      out_q   <= '0;
    end else begin
      ready_q <= acc;
      if (acc && wr) begin
        case (off)
          OFF_CTRL: dir_q <= dir_wr[NUM_GPIO-1:0];
          OFF_DATA: out_q <= out_wr[NUM_GPIO-1:0];
          default:  ;
        endcase
      end
    end
  end

  // two-flop synchronizer on the pins, read data captured with the ack
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
    if (acc) begin
      rdata_q <= rdata;
    end
  end

  assign rsp_o      = '{ready: ready_q, rdata: rdata_q};
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

`default_nettype wire

// File: rtl/nmi_periph_wrapper.sv
// nmi peripheral wrapper: routes the bus to gpio, uart and two timers and merges their responses
`timescale 1ns/1ps
`default_nettype none

module nmi_periph_wrapper #(
  parameter int NUM_GPIO = 8
) (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire nmi_pkg::nmi_req_t   nmi_req_i,
  output nmi_pkg::nmi_rsp_t        nmi_rsp_o,
  input  wire logic [NUM_GPIO-1:0] gpio_in_i,
  output logic [NUM_GPIO-1:0]      gpio_out_o,
  output logic [NUM_GPIO-1:0]      gpio_oe_o,
  output logic                     uart_tx_o,
  output logic [2:0]               irq_o
);
  import nmi_pkg::*;
  import periph_pkg::*;

  periph_sel_e sel;
  nmi_req_t    gpio_req;
  nmi_req_t    uart_req;
  nmi_req_t    tim0_req;
  nmi_req_t    tim1_req;
  nmi_rsp_t    gpio_rsp;
  nmi_rsp_t    uart_rsp;
  nmi_rsp_t    tim0_rsp;
  nmi_rsp_t    tim1_rsp;
  nmi_rsp_t    none_rsp;
  logic        none_valid;
  logic        none_ready_q;
  logic        uart_done;

  function automatic nmi_req_t gate_req(nmi_req_t req, logic hit);
    nmi_req_t res;
    res       = req;
    res.valid = req.valid & hit;
    return res;
  endfunction

  function automatic nmi_rsp_t gate_rsp(nmi_rsp_t rsp, logic hit);
    return hit ? rsp : '0;
  endfunction

  // anything outside the window or with an unknown block code lands on SEL_NONE
  always_comb begin
    sel = SEL_NONE;
    if (nmi_req_i.addr[31:24] == REG_BASE) begin
      case (nmi_req_i.addr[15:8])
        SEL_GPIO, SEL_UART, SEL_TIM0, SEL_TIM1: sel = periph_sel_e'(nmi_req_i.addr[15:8]);
        default:                                sel = SEL_NONE;
      endcase
    end
  end

  assign gpio_req = gate_req(nmi_req_i, sel == SEL_GPIO);
  assign uart_req = gate_req(nmi_req_i, sel == SEL_UART);
  assign tim0_req = gate_req(nmi_req_i, sel == SEL_TIM0);
  assign tim1_req = gate_req(nmi_req_i, sel == SEL_TIM1);

  // unmapped responder, acks one cycle later with zero data
  assign none_valid = nmi_req_i.valid && (sel == SEL_NONE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      none_ready_q <= 1'b0;
    end else begin
      none_ready_q <= none_valid && !none_ready_q;
    end
  end

  assign none_rsp = '{ready: none_ready_q, rdata: '0};

  assign nmi_rsp_o = gate_rsp(gpio_rsp, sel == SEL_GPIO) |
                     gate_rsp(uart_rsp, sel == SEL_UART) |
                     gate_rsp(tim0_rsp, sel == SEL_TIM0) |
                     gate_rsp(tim1_rsp, sel == SEL_TIM1) |
                     gate_rsp(none_rsp, sel == SEL_NONE);

  assign irq_o[0] = uart_done;

  nmi_gpio #(
    .NUM_GPIO(NUM_GPIO)
  ) u_gpio (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (gpio_req),
    .rsp_o     (gpio_rsp),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o)
  );

  nmi_uart_tx u_uart_tx (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (uart_req),
    .rsp_o    (uart_rsp),
    .uart_tx_o(uart_tx_o),
    .done_o   (uart_done)
  );

  nmi_timer u_timer0 (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (tim0_req),
    .rsp_o  (tim0_rsp),
    .irq_o  (irq_o[1])
  );

  nmi_timer u_timer1 (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (tim1_req),
    .rsp_o  (tim1_rsp),
    .irq_o  (irq_o[2])
  );

endmodule

`default_nettype wire

// File: rtl/nmi_pkg.sv
// nmi bus package: request and response types shared by the master and every register block
`default_nettype none

package nmi_pkg;

  // bus widths
  localparam int NMI_AW = 32;
  localparam int NMI_DW = 32;

  // one strobe bit per data byte
  localparam int NMI_SW = NMI_DW / 8;

  // request side
  // master holds addr, wdata and wstrb stable while valid is high and ready is low
  // an all-zero wstrb marks a read
  typedef struct packed {
    logic              valid;
    logic [NMI_AW-1:0] addr;
    logic [NMI_DW-1:0] wdata;
    logic [NMI_SW-1:0] wstrb;
  } nmi_req_t;

  // response side
  // ready is a single-cycle pulse per transfer
  // rdata only carries meaning in that cycle
  typedef struct packed {
    logic              ready;
    logic [NMI_DW-1:0] rdata;
  } nmi_rsp_t;

  // the master may drop valid or present a new request in the cycle after ready,
  // so a block rearms one cycle after each ack

endpackage

`default_nettype wire

// File: rtl/nmi_timer.sv
// timer block: 32-bit up counter with reload, sticky overflow flag and maskable interrupt
`timescale 1ns/1ps
`default_nettype none

module nmi_timer (
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire nmi_pkg::nmi_req_t req_i,
  output nmi_pkg::nmi_rsp_t      rsp_o,
  output logic                   irq_o
);
  import nmi_pkg::*;
  import periph_pkg::*;

  reg_off_e          off;
  logic              acc;
  logic              wr;
  logic              ready_q;
  logic [NMI_DW-1:0] rdata;
  logic [NMI_DW-1:0] rdata_q;
  logic              en_q;
  logic              irq_en_q;
  logic              ovf_q;
  logic [NMI_DW-1:0] reload_q;
  logic [NMI_DW-1:0] count_q;
  logic              wrap;
  logic              ovf_clr;

  assign off = reg_off_e'(req_i.addr[5:2]);
  assign wr  = |req_i.wstrb;
  assign acc = req_i.valid && !ready_q;

  // a reload written below the running count still wraps at once
  assign wrap    = en_q && (count_q >= reload_q);
  assign ovf_clr = acc && wr && (off == OFF_STAT) && req_i.wdata[0];

  always_comb begin
    case (off)
      OFF_CTRL: rdata = NMI_DW'({irq_en_q, en_q});
      OFF_DATA: rdata = reload_q;
      OFF_STAT: rdata = NMI_DW'(ovf_q);
      OFF_AUX:  rdata = count_q;
      default:  rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q  <= 1'b0;
      en_q     <= 1'b0;
      irq_en_q <= 1'b0;
      ovf_q    <= 1'b0;
      reload_q <= '0;
      count_q  <= '0;
    end else begin
      ready_q <= acc;
      if (acc && wr && (off == OFF_CTRL)) begin
        en_q     <= req_i.wdata[0];
        irq_en_q <= req_i.wdata[1];
      end
      if (acc && wr && (off == OFF_DATA)) begin
        reload_q <= req_i.wdata;
      end
      // count holds while disabled
      if (en_q) begin
        count_q <= wrap ? '0 : count_q + 1'b1;
      end
      // a new overflow beats a clear arriving in the same cycle
      if (wrap) begin
        ovf_q <= 1'b1;
      end else if (ovf_clr) begin
        ovf_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      rdata_q <= rdata;
    end
  end

  assign rsp_o = '{ready: ready_q, rdata: rdata_q};
  assign irq_o = ovf_q & irq_en_q;

endmodule

`default_nettype wire

// File: rtl/nmi_uart_tx.sv
// uart transmitter: 8N1 frames at a programmable divisor, stalls data writes while busy
`timescale 1ns/1ps
`default_nettype none

module nmi_uart_tx (
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire nmi_pkg::nmi_req_t req_i,
  output nmi_pkg::nmi_rsp_t      rsp_o,
  output logic                   uart_tx_o,
  output logic                   done_o
);
  import nmi_pkg::*;
  import periph_pkg::*;

  uart_state_e           state_q;
  reg_off_e              off;
  logic                  wr;
  logic                  data_wr;
  logic                  busy;
  logic                  stall;
  logic                  acc;
  logic                  launch;
  logic                  bit_end;
  logic                  ready_q;
  logic [NMI_DW-1:0]     rdata;
  logic [NMI_DW-1:0]     rdata_q;
  logic [UART_DIV_W-1:0] div_q;
  logic [UART_DIV_W-1:0] div_cnt_q;
  logic [2:0]            bit_cnt_q;
  logic [7:0]            shift_q;
  logic                  tx_q;
  logic                  done_q;

  assign off     = reg_off_e'(req_i.addr[5:2]);
  assign wr      = |req_i.wstrb;
  assign data_wr = req_i.valid && wr && (off == OFF_DATA);
  assign busy    = (state_q != UART_IDLE);
  // back-pressure: a data write waits until the frame in flight is done
  assign stall   = data_wr && busy;
  assign acc     = req_i.valid && !ready_q && !stall;
  // master still holds the request in the ack cycle, frame starts on the next edge
  assign launch  = ready_q && data_wr;
  assign bit_end = (div_cnt_q >= div_q - 1'b1);

  always_comb begin
    case (off)
      OFF_CTRL: rdata = NMI_DW'(div_q);
      OFF_STAT: rdata = NMI_DW'(busy);
      default:  rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= UART_IDLE;
      ready_q   <= 1'b0;
      div_q     <= UART_DIV_RST;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
      tx_q      <= 1'b1;
      done_q    <= 1'b0;
    end else begin
      ready_q <= acc;
      done_q  <= 1'b0;
      if (acc && wr && (off == OFF_CTRL)) begin
        div_q <= req_i.wdata[UART_DIV_W-1:0];
      end
      if (busy) begin
        div_cnt_q <= bit_end ? '0 : div_cnt_q + 1'b1;
      end
      case (state_q)
        UART_IDLE: begin
          if (launch) begin
            state_q <= UART_START;
            tx_q    <= 1'b0;
          end
        end
        UART_START: begin
          if (bit_end) begin
            state_q   <= UART_DATA;
            bit_cnt_q <= '0;
            tx_q      <= shift_q[0];
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= UART_STOP;
              tx_q    <= 1'b1;
            end else begin
              tx_q <= shift_q[1];
            end
          end
        end
        UART_STOP: begin
          if (bit_end) begin
            state_q <= UART_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // shifter walks LSB first, tx_q always takes bit 0 of the next value
  always_ff @(posedge clk_i) begin
    if (launch) begin
      shift_q <= req_i.wdata[7:0];
    end else if ((state_q == UART_DATA) && bit_end) begin
      shift_q <= shift_q >> 1;
    end
    if (acc) begin
      rdata_q <= rdata;
    end
  end

  assign rsp_o     = '{ready: ready_q, rdata: rdata_q};
  assign uart_tx_o = tx_q;
  assign done_o    = done_q;

endmodule

`default_nettype wire

// File: rtl/periph_pkg.sv
// peripheral map package: register window, block codes, register offsets and uart state types
`default_nettype none

package periph_pkg;

  // register window, compared against addr[31:24]
  localparam logic [7:0] REG_BASE = 8'h10;

  // block codes, compared against addr[15:8]
  // SEL_NONE is only a decode result and never matched against an address
  typedef enum logic [7:0] {
    SEL_GPIO = 8'h00,
    SEL_UART = 8'h10,
    SEL_TIM0 = 8'h20,
    SEL_TIM1 = 8'h30,
    SEL_NONE = 8'hff
  } periph_sel_e;

  // word offsets inside a block, taken from addr[5:2]
  typedef enum logic [3:0] {
    OFF_CTRL = 4'd0,
    OFF_DATA = 4'd1,
    OFF_STAT = 4'd2,
    OFF_AUX  = 4'd3
  } reg_off_e;

  // uart divisor width and its value out of reset, in clocks per bit
  localparam int                    UART_DIV_W   = 16;
  localparam logic [UART_DIV_W-1:0] UART_DIV_RST = 16'd16;

  // transmitter frame phases
  typedef enum logic [1:0] {
    UART_IDLE  = 2'd0,
    UART_START = 2'd1,
    UART_DATA  = 2'd2,
    UART_STOP  = 2'd3
  } uart_state_e;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it and search the log for the result

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f project.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
  exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
  echo "no result line found in $LOG"
  exit 1
fi
exit 0
